/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_sram_top
FILELIST  = build.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +incdir+%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
logic/sram_pkg.sv
logic/wb_responder.sv
logic/sram_fsm.sv
logic/sram_timer.sv
logic/sram_datapath.sv
logic/sram_top.sv
test/sram_model.sv
test/tb_sram_top.sv

/* logic/sram_datapath.sv */
`timescale 1ns/10ps

module sram_datapath (
    input  logic                                       i_wb_clk,
    input  logic                                       i_rst_n,

    // Control from the state machine
    input  logic                                       i_latch,
    input  logic                                       i_drive,
    input  logic                                       i_capture,
    input  logic                                       i_lane_en,

    input  sram_pkg::sram_req_t                        i_req,
    output logic [sram_pkg::SRAM_DATA_WIDTH-1:0]       o_rdata,

    // SRAM pins
    output logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]       o_sram_addr,
    output logic                                       o_sram_lb_n,
    output logic                                       o_sram_ub_n,
    inout  wire logic [sram_pkg::SRAM_DATA_WIDTH-1:0]  io_sram_dq
);

    logic [sram_pkg::WB_SEL_WIDTH-1:0]     sel_q;
    logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]  addr_q;
    logic [sram_pkg::SRAM_DATA_WIDTH-1:0]  wdata_q;

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sel_q <= '0;
        end else if (i_latch) begin
            sel_q <= i_req.sel;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_latch) begin
            addr_q  <= i_req.addr;
            wdata_q <= i_req.wdata;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_capture) begin
            o_rdata <= io_sram_dq;
        end
    end

    assign o_sram_addr = addr_q;

    // Byte lanes, active low, only during an access
    assign o_sram_lb_n = ~(i_lane_en & sel_q[0]);
    assign o_sram_ub_n = ~(i_lane_en & sel_q[1]);

    assign io_sram_dq = i_drive ? wdata_q : {sram_pkg::SRAM_DATA_WIDTH{1'bz}};

endmodule

/* logic/sram_fsm.sv */
`timescale 1ns/10ps

module sram_fsm (
    input  logic                                 i_wb_clk,
    input  logic                                 i_rst_n,

    // Request handshake
    input  logic                                 i_req_en,
    input  logic                                 i_req_we,
    output logic                                 o_done,

    // Wait-state timer
    output logic                                 o_tmr_load,
    output logic [sram_pkg::TIMER_WIDTH-1:0]     o_tmr_count,
    input  logic                                 i_expired,

    // Datapath control
    output logic                                 o_latch,
    output logic                                 o_drive,
    output logic                                 o_capture,
    output logic                                 o_lane_en,

    // SRAM control pins
    output logic                                 o_sram_ce_n,
    output logic                                 o_sram_oe_n,
    output logic                                 o_sram_we_n
);

    sram_pkg::sram_state_t state;
    sram_pkg::sram_state_t state_next;

    logic start;
    logic active;

    assign start  = (state == sram_pkg::IDLE) && i_req_en;
    assign active = (state == sram_pkg::READ) || (state == sram_pkg::WRITE) ||
                    (state == sram_pkg::TURN);

    always_comb begin
        state_next = state;

        case (state)
            sram_pkg::IDLE: begin
                if (i_req_en) begin
                    state_next = i_req_we ? sram_pkg::WRITE : sram_pkg::READ;
                end
            end
            sram_pkg::READ: begin
                if (i_expired) begin
                    state_next = sram_pkg::DONE;
                end
            end
            sram_pkg::WRITE: begin
                if (i_expired) begin
                    state_next = sram_pkg::TURN;
                end
            end
            sram_pkg::TURN:  state_next = sram_pkg::DONE;    // WE high, data held
            sram_pkg::DONE:  state_next = sram_pkg::IDLE;
            default:         state_next = sram_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= sram_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Timer runs out on the last cycle of the phase
    assign o_tmr_load  = start;
    assign o_tmr_count = i_req_we ? (sram_pkg::SRAM_WR_WAIT - 1'b1)
                                  : (sram_pkg::SRAM_RD_WAIT - 1'b1);

    assign o_latch   = start;
    assign o_capture = (state == sram_pkg::READ) && i_expired;    // Last read cycle

    // Data stays on the pins through TURN so it outlasts the WE rising edge
    assign o_drive   = (state == sram_pkg::WRITE) || (state == sram_pkg::TURN);
    assign o_done    = (state == sram_pkg::DONE);
    assign o_lane_en = active;

    assign o_sram_ce_n = ~active;
    assign o_sram_oe_n = ~(state == sram_pkg::READ);
    assign o_sram_we_n = ~(state == sram_pkg::WRITE);

endmodule

/* logic/sram_pkg.sv */
package sram_pkg;

    // Wishbone bus
    localparam int WB_DATA_WIDTH = 16;
    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = 2;
    localparam int WB_CTI_WIDTH  = 3;

    // Cycle type identifier codes
    localparam logic [WB_CTI_WIDTH-1:0] CTI_CLASSIC = 3'b000;
    localparam logic [WB_CTI_WIDTH-1:0] CTI_INCR    = 3'b010;
    localparam logic [WB_CTI_WIDTH-1:0] CTI_END     = 3'b111;

    // External SRAM, 1M x 16
    localparam int SRAM_ADDR_WIDTH = 20;
    localparam int SRAM_DATA_WIDTH = 16;

    localparam logic [WB_ADDR_WIDTH-1:0] SRAM_BASE_ADDR = 32'h0000_0000;
    localparam logic [WB_ADDR_WIDTH-1:0] SRAM_ADDR_SPAN = 32'd2097152;   // 2M bytes

    // Wait states, counted in bus clock cycles
    localparam int TIMER_WIDTH = 3;
    localparam logic [TIMER_WIDTH-1:0] SRAM_RD_WAIT = 3'd2;    // OE low
    localparam logic [TIMER_WIDTH-1:0] SRAM_WR_WAIT = 3'd2;    // WE low

    typedef struct packed {
        logic                       we;
        logic                       eob;      // Last beat of the cycle
        logic [WB_SEL_WIDTH-1:0]    sel;
        logic [SRAM_ADDR_WIDTH-1:0] addr;     // Word address
        logic [WB_DATA_WIDTH-1:0]   wdata;
    } sram_req_t;

    typedef struct packed {
        logic                       done;     // Single cycle pulse
        logic [SRAM_DATA_WIDTH-1:0] rdata;
    } sram_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        WRITE,
        TURN,
        DONE
    } sram_state_t;

endpackage

/* logic/sram_timer.sv */
`timescale 1ns/10ps

module sram_timer (
    input  logic                                 i_wb_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_load,
    input  logic [sram_pkg::TIMER_WIDTH-1:0]     i_count,
    output logic                                 o_expired
);

    logic [sram_pkg::TIMER_WIDTH-1:0] count;

    // Counts down to zero and parks there
    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;
        end else if (i_load) begin
            count <= i_count;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign o_expired = (count == '0);

endmodule

/* logic/sram_top.sv */
`timescale 1ns/10ps

module sram_top (
    // Wishbone interface
    input  logic                                       i_wb_clk,
    input  logic                                       i_rst_n,
    input  logic                                       i_wb_cyc,
    input  logic                                       i_wb_stb,
    input  logic                                       i_wb_we,
    input  logic [sram_pkg::WB_CTI_WIDTH-1:0]          i_wb_cti,
    input  logic [sram_pkg::WB_SEL_WIDTH-1:0]          i_wb_sel,
    input  logic [sram_pkg::WB_ADDR_WIDTH-1:0]         i_wb_addr,
    input  logic [sram_pkg::WB_DATA_WIDTH-1:0]         i_wb_data,
    output logic [sram_pkg::WB_DATA_WIDTH-1:0]         o_wb_data,
    output logic                                       o_wb_ack,

    // SRAM interface
    output logic                                       o_sram_ce_n,
    output logic                                       o_sram_oe_n,
    output logic                                       o_sram_we_n,
    output logic                                       o_sram_lb_n,
    output logic                                       o_sram_ub_n,
    output logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]       o_sram_addr,
    inout  wire logic [sram_pkg::SRAM_DATA_WIDTH-1:0]  io_sram_dq
);

    logic                                    req_en;
    sram_pkg::sram_req_t                     req;
    sram_pkg::sram_rsp_t                     rsp;

    logic                                    tmr_load;
    logic [sram_pkg::TIMER_WIDTH-1:0]        tmr_count;
    logic                                    tmr_expired;

    logic                                    latch;
    logic                                    drive;
    logic                                    capture;
    logic                                    lane_en;
    logic                                    done;
    logic [sram_pkg::SRAM_DATA_WIDTH-1:0]    rdata;

    assign rsp = sram_pkg::sram_rsp_t'{done: done, rdata: rdata};

    wb_responder wb_responder_inst (
        .i_wb_clk   (i_wb_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_cti   (i_wb_cti),
        .i_wb_sel   (i_wb_sel),
        .i_wb_addr  (i_wb_addr),
        .i_wb_data  (i_wb_data),
        .o_wb_data  (o_wb_data),
        .o_wb_ack   (o_wb_ack),
        .o_req_en   (req_en),
        .o_req      (req),
        .i_rsp      (rsp)
    );

    sram_fsm sram_fsm_inst (
        .i_wb_clk    (i_wb_clk),
        .i_rst_n     (i_rst_n),
        .i_req_en    (req_en),
        .i_req_we    (req.we),
        .o_done      (done),
        .o_tmr_load  (tmr_load),
        .o_tmr_count (tmr_count),
        .i_expired   (tmr_expired),
        .o_latch     (latch),
        .o_drive     (drive),
        .o_capture   (capture),
        .o_lane_en   (lane_en),
        .o_sram_ce_n (o_sram_ce_n),
        .o_sram_oe_n (o_sram_oe_n),
        .o_sram_we_n (o_sram_we_n)
    );

    sram_timer sram_timer_inst (
        .i_wb_clk  (i_wb_clk),
        .i_rst_n   (i_rst_n),
        .i_load    (tmr_load),
        .i_count   (tmr_count),
        .o_expired (tmr_expired)
    );

    sram_datapath sram_datapath_inst (
        .i_wb_clk    (i_wb_clk),
        .i_rst_n     (i_rst_n),
        .i_latch     (latch),
        .i_drive     (drive),
        .i_capture   (capture),
        .i_lane_en   (lane_en),
        .i_req       (req),
        .o_rdata     (rdata),
        .o_sram_addr (o_sram_addr),
        .o_sram_lb_n (o_sram_lb_n),
        .o_sram_ub_n (o_sram_ub_n),
        .io_sram_dq  (io_sram_dq)
    );

endmodule

/* logic/wb_responder.sv */
`timescale 1ns/10ps

module wb_responder (
    input  logic                                  i_wb_clk,
    input  logic                                  i_rst_n,

    // Wishbone slave
    input  logic                                  i_wb_cyc,
    input  logic                                  i_wb_stb,
    input  logic                                  i_wb_we,
    input  logic [sram_pkg::WB_CTI_WIDTH-1:0]     i_wb_cti,
    input  logic [sram_pkg::WB_SEL_WIDTH-1:0]     i_wb_sel,
    input  logic [sram_pkg::WB_ADDR_WIDTH-1:0]    i_wb_addr,
    input  logic [sram_pkg::WB_DATA_WIDTH-1:0]    i_wb_data,
    output logic [sram_pkg::WB_DATA_WIDTH-1:0]    o_wb_data,
    output logic                                  o_wb_ack,

    // Request to the SRAM side
    output logic                                  o_req_en,
    output sram_pkg::sram_req_t                   o_req,
    input  sram_pkg::sram_rsp_t                   i_rsp
);

    logic                                   in_window;
    logic                                   accept;
    logic [sram_pkg::WB_ADDR_WIDTH-1:0]     offset;
    logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]   word_addr;

    // Address decode against the SRAM window
    assign in_window = (i_wb_addr >= sram_pkg::SRAM_BASE_ADDR) &&
                       (i_wb_addr < (sram_pkg::SRAM_BASE_ADDR + sram_pkg::SRAM_ADDR_SPAN));

    assign offset    = i_wb_addr - sram_pkg::SRAM_BASE_ADDR;
    assign word_addr = offset[sram_pkg::SRAM_ADDR_WIDTH:1];   // Byte to 16-bit word

    // No new beat while one is in flight or still being acknowledged
    assign accept = i_wb_cyc & i_wb_stb & in_window & ~o_req_en & ~o_wb_ack;

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_req_en <= 1'b0;
        end else if (accept) begin
            o_req_en <= 1'b1;
        end else if (i_rsp.done) begin
            o_req_en <= 1'b0;
        end
    end

    // Request payload, stable while o_req_en is high
    always_ff @(posedge i_wb_clk) begin
        if (accept) begin
            o_req.we    <= i_wb_we;
            o_req.eob   <= (i_wb_cti != sram_pkg::CTI_INCR);
            o_req.sel   <= i_wb_sel;
            o_req.addr  <= word_addr;
            o_req.wdata <= i_wb_data;
        end
    end

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= i_rsp.done;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_rsp.done) begin
            o_wb_data <= i_rsp.rdata;    // Valid together with o_wb_ack
        end
    end

endmodule

/* test/sram_model.sv */
`timescale 1ns/10ps

module sram_model (
    input  logic                                       i_ce_n,
    input  logic                                       i_oe_n,
    input  logic                                       i_we_n,
    input  logic                                       i_lb_n,
    input  logic                                       i_ub_n,
    input  logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]       i_addr,
    inout  wire logic [sram_pkg::SRAM_DATA_WIDTH-1:0]  io_dq
);

    localparam int DEPTH = 1 << sram_pkg::SRAM_ADDR_WIDTH;

    logic [sram_pkg::SRAM_DATA_WIDTH-1:0] mem [DEPTH];
    logic [sram_pkg::SRAM_DATA_WIDTH-1:0] rd_word;
    logic                                 read_en;

    assign read_en = ~i_ce_n & ~i_oe_n & i_we_n;    // WE low wins over OE
    assign rd_word = mem[i_addr];

    // Each byte lane drives only when it is selected
    assign io_dq[7:0]  = (read_en & ~i_lb_n) ? rd_word[7:0]  : 8'hzz;
    assign io_dq[15:8] = (read_en & ~i_ub_n) ? rd_word[15:8] : 8'hzz;

    // Write cycle completes on the rising edge of WE
    always @(posedge i_we_n) begin
        if (!i_ce_n) begin
            if (!i_lb_n) begin
                mem[i_addr][7:0] <= io_dq[7:0];
            end
            if (!i_ub_n) begin
                mem[i_addr][15:8] <= io_dq[15:8];
            end
        end
    end

endmodule

/* test/tb_sram_top.sv */
`timescale 1ns/10ps

module tb_sram_top;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int RD_LATENCY   = 5;    // Strobe to acknowledge from an idle bus
    localparam int WR_LATENCY   = 6;
    localparam int RAND_WORDS   = 20;
    localparam int BURST_LEN    = 4;

    typedef struct packed {
        logic                                   we;
        logic [sram_pkg::WB_CTI_WIDTH-1:0]      cti;
        logic [sram_pkg::WB_ADDR_WIDTH-1:0]     addr;
        logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]   waddr;    // Expected on the SRAM pins
        logic [sram_pkg::WB_SEL_WIDTH-1:0]      sel;
        logic [sram_pkg::WB_DATA_WIDTH-1:0]     wdata;
        logic [sram_pkg::WB_DATA_WIDTH-1:0]     rdata;    // Expected on reads
    } beat_t;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   wb_cyc;
    logic                                   wb_stb;
    logic                                   wb_we;
    logic [sram_pkg::WB_CTI_WIDTH-1:0]      wb_cti;
    logic [sram_pkg::WB_SEL_WIDTH-1:0]      wb_sel;
    logic [sram_pkg::WB_ADDR_WIDTH-1:0]     wb_addr;
    logic [sram_pkg::WB_DATA_WIDTH-1:0]     wb_wdata;
    logic [sram_pkg::WB_DATA_WIDTH-1:0]     wb_rdata;
    logic                                   wb_ack;
    logic                                   sram_ce_n;
    logic                                   sram_oe_n;
    logic                                   sram_we_n;
    logic                                   sram_lb_n;
    logic                                   sram_ub_n;
    logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]   sram_addr;
    tri1  [sram_pkg::SRAM_DATA_WIDTH-1:0]   sram_dq;    // Reads all ones when released

    beat_t                                  table_q[$];
    logic [15:0]                            shadow [logic [sram_pkg::SRAM_ADDR_WIDTH-1:0]];
    bit                                     table_ready = 1'b0;
    int                                     ack_count = 0;

    sram_top UUT (
        .i_wb_clk    (clk),
        .i_rst_n     (rst_n),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_cti    (wb_cti),
        .i_wb_sel    (wb_sel),
        .i_wb_addr   (wb_addr),
        .i_wb_data   (wb_wdata),
        .o_wb_data   (wb_rdata),
        .o_wb_ack    (wb_ack),
        .o_sram_ce_n (sram_ce_n),
        .o_sram_oe_n (sram_oe_n),
        .o_sram_we_n (sram_we_n),
        .o_sram_lb_n (sram_lb_n),
        .o_sram_ub_n (sram_ub_n),
        .o_sram_addr (sram_addr),
        .io_sram_dq  (sram_dq)
    );

    sram_model sram_chip (
        .i_ce_n (sram_ce_n),
        .i_oe_n (sram_oe_n),
        .i_we_n (sram_we_n),
        .i_lb_n (sram_lb_n),
        .i_ub_n (sram_ub_n),
        .i_addr (sram_addr),
        .io_dq  (sram_dq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (wb_ack === 1'b1) begin
            ack_count <= ack_count + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] byte_addr(input logic [19:0] waddr);
        return sram_pkg::SRAM_BASE_ADDR + {11'b0, waddr, 1'b0};
    endfunction

    // Shadow word takes only the selected bytes
    task automatic add_write(input logic [19:0] waddr, input logic [1:0] sel,
                             input logic [15:0] data, input logic [2:0] cti);
        logic [15:0] word;
        beat_t       b;
        word = shadow.exists(waddr) ? shadow[waddr] : 16'h0000;
        if (sel[0]) begin
            word[7:0] = data[7:0];
        end
        if (sel[1]) begin
            word[15:8] = data[15:8];
        end
        shadow[waddr] = word;
        b = '{we: 1'b1, cti: cti, addr: byte_addr(waddr), waddr: waddr, sel: sel,
              wdata: data, rdata: 16'h0};
        table_q.push_back(b);
    endtask

    task automatic add_read(input logic [19:0] waddr, input logic [2:0] cti);
        beat_t b;
        b = '{we: 1'b0, cti: cti, addr: byte_addr(waddr), waddr: waddr, sel: 2'b11,
              wdata: 16'h0, rdata: shadow[waddr]};
        table_q.push_back(b);
    endtask

    task automatic build_table();
        logic [19:0] rand_addr [RAND_WORDS];
        logic [2:0]  cti;
        int          i;
        add_write(20'h00000, 2'b11, 16'hA5C3, sram_pkg::CTI_CLASSIC);    // Bottom of window
        add_write(20'h00001, 2'b11, 16'h5A3C, sram_pkg::CTI_CLASSIC);
        add_write(20'h12345, 2'b11, 16'h0F1E, sram_pkg::CTI_CLASSIC);
        add_write(20'hFFFFF, 2'b11, 16'h8001, sram_pkg::CTI_CLASSIC);    // Top of window
        add_read(20'h00000, sram_pkg::CTI_CLASSIC);
        add_read(20'h00001, sram_pkg::CTI_CLASSIC);
        add_read(20'h12345, sram_pkg::CTI_CLASSIC);
        add_read(20'hFFFFF, sram_pkg::CTI_CLASSIC);
        // Lower byte from the first write, upper from the second
        add_write(20'h00100, 2'b01, 16'hDEAD, sram_pkg::CTI_CLASSIC);
        add_write(20'h00100, 2'b10, 16'hBEEF, sram_pkg::CTI_CLASSIC);
        add_read(20'h00100, sram_pkg::CTI_CLASSIC);
        for (i = 0; i < BURST_LEN; i++) begin
            cti = (i == BURST_LEN - 1) ? sram_pkg::CTI_END : sram_pkg::CTI_INCR;
            add_write(20'h00200 + 20'(i), 2'b11, 16'($urandom), cti);
        end
        for (i = 0; i < BURST_LEN; i++) begin
            cti = (i == BURST_LEN - 1) ? sram_pkg::CTI_END : sram_pkg::CTI_INCR;
            add_read(20'h00200 + 20'(i), cti);
        end
        for (i = 0; i < RAND_WORDS; i++) begin
            rand_addr[i] = 20'($urandom_range(0, 32'h000F_FFFF));
            add_write(rand_addr[i], 2'b11, 16'($urandom), sram_pkg::CTI_CLASSIC);
        end
        for (i = 0; i < RAND_WORDS; i++) begin
            add_read(rand_addr[i], sram_pkg::CTI_CLASSIC);
        end
        // Read right behind a write needs the bus turned around
        add_write(20'h00300, 2'b11, 16'h3C96, sram_pkg::CTI_CLASSIC);
        add_read(20'h00300, sram_pkg::CTI_CLASSIC);
    endtask

    // Starts on a falling edge and returns on one
    task automatic run_beat(input beat_t b, input bit chained);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = b.we;
        wb_cti   = b.cti;
        wb_sel   = b.sel;
        wb_addr  = b.addr;
        wb_wdata = b.wdata;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (wb_ack !== 1'b1);
        check_value("o_sram_addr", 32'(sram_addr), 32'(b.waddr));
        if (!b.we) begin
            check_value("o_wb_data", 32'(wb_rdata), 32'(b.rdata));
        end
        if (!chained) begin
            check_value("o_wb_ack latency", 32'(waited),
                        b.we ? 32'(WR_LATENCY) : 32'(RD_LATENCY));
        end
        if (b.cti != sram_pkg::CTI_INCR) begin
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            @(negedge clk);
        end
    endtask

    initial begin
        int i;
        bit chained;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_cti   = sram_pkg::CTI_CLASSIC;
        wb_sel   = '0;
        wb_addr  = '0;
        wb_wdata = '0;
        void'($urandom(95));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("SRAM control pins", 32'({sram_ce_n, sram_oe_n, sram_we_n,
                                              sram_lb_n, sram_ub_n}), 32'h1F);
        check_value("o_wb_ack", 32'(wb_ack), 32'h0);
        check_value("io_sram_dq", 32'(sram_dq), 32'hFFFF);
        for (i = 0; i < table_q.size(); i++) begin
            chained = 1'b0;
            if (i > 0) begin
                chained = (table_q[i-1].cti == sram_pkg::CTI_INCR);
            end
            run_beat(table_q[i], chained);
        end
        check_value("acknowledge count", 32'(ack_count), 32'(table_q.size()));
        $display("Test OK");
        $finish;
    end

    // Twenty cycles per beat is well above the slowest access
    initial begin
        wait (table_ready);
        repeat (table_q.size() * 20 + RESET_CYCLES + 2) @(posedge clk);
        $display("Timeout: the Wishbone acknowledge never came");
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
